// File: Bender.yml
package:
  name: tri_setup

sources:
  - include_dirs:
      - common
    files:
      - common/tri_setup_pkg.sv
      - logic/flt_fx.sv
      - setup_regs/setup_decode.sv
      - setup_regs/setup_execute.sv
      - setup_regs/des_reg.sv
      - logic/tri_setup_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/tb_clk_gen.sv
      - dv/tri_setup_asserts.sv
      - dv/tri_setup_tb.sv

// File: common/tri_setup_pkg.sv
`include "tri_setup_settings.svh"

package tri_setup_pkg;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic                  awvalid;
		logic [`TS_ADDR_W-1:0] awaddr;
		logic                  wvalid;
		logic [31:0]           wdata;
		logic [3:0]            wstrb;
		logic                  bready;
		logic                  arvalid;
		logic [`TS_ADDR_W-1:0] araddr;
		logic                  rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	typedef struct packed {
		logic        sign;
		logic [7:0]  expo;
		logic [22:0] man;
	} flt_view_t;

	typedef struct packed {
		logic signed [15:0] ip;
		logic [15:0]        frac;
	} fix_view_t;

	// same 32 bits, ieee single or 16.16
	typedef union packed {
		flt_view_t flt;
		fix_view_t fix;
	} flt_word_u;

	typedef enum logic [2:0] {
		CL_ESLOPE, CL_EINT, CL_NS1, CL_NS2, CL_SPY, CL_VTX, CL_ATTR, CL_YSTAT
	} ld_cls_e;

	typedef struct packed {
		logic       ld;     // staging write this cycle
		ld_cls_e    cls;
		logic [3:0] idx;    // word within the class
		logic       commit;
	} stage_ld_t;

	typedef struct packed {
		logic [31:0] start;
		logic [31:0] dx;
		logic [31:0] dy;
	} attr_plane_t;

	typedef struct packed {
		logic [2:0][31:0] es;   // 16.16 edge slopes
		logic [2:0][31:0] ex;   // 16.16 edge intercepts
		logic [15:0]      spx;
		logic [15:0]      spy;
		logic [15:0]      ns1;
		logic [15:0]      ns2;
		attr_plane_t [`TS_NUM_ATTR-1:0] attr;
		logic [31:0]      start_x;
		logic [31:0]      start_y;
		logic [31:0]      end_x;
		logic [31:0]      end_y;
		logic             scan_dir;
		logic             line_mode;
	} tri_desc_t;

endpackage

// File: common/tri_setup_settings.svh
`ifndef TRI_SETUP_SETTINGS_SVH
`define TRI_SETUP_SETTINGS_SVH

// register port geometry
`define TS_ADDR_W         8
`define TS_NUM_ATTR       4

// byte offsets, word aligned
`define TS_REG_COMMIT     8'h00
`define TS_REG_YSTAT      8'h04
`define TS_REG_E1S        8'h08
`define TS_REG_E2S        8'h0C
`define TS_REG_E3S        8'h10
`define TS_REG_E1X        8'h14
`define TS_REG_E2X        8'h18
`define TS_REG_E3X        8'h1C
`define TS_REG_NS1        8'h20
`define TS_REG_NS2        8'h24
`define TS_REG_SPY        8'h28
`define TS_REG_V0X        8'h2C
`define TS_REG_V0Y        8'h30
`define TS_REG_V2X        8'h34
`define TS_REG_V2Y        8'h38

// three words per attribute: start, dx, dy
`define TS_REG_ATTR_BASE  8'h40

`endif

// File: dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
	output logic se_clk,
	output logic se_rstn
);

	initial begin
		se_clk = 1'b0;
		forever #2 se_clk = ~se_clk; // 4 ns period
	end

	initial begin
		se_rstn = 1'b0;
		repeat (3) @(posedge se_clk);
		#1 se_rstn = 1'b1;
	end

endmodule

// File: dv/tri_setup_asserts.sv
`timescale 1ns/10ps

module tri_setup_asserts (
	input logic                     se_clk,
	input logic                     se_rstn,
	input tri_setup_pkg::axil_req_t axil_req,
	input tri_setup_pkg::axil_rsp_t axil_rsp,
	input tri_setup_pkg::tri_desc_t desc,
	input logic                     desc_valid,
	input logic                     desc_ready
);

	int fail_cnt = 0; // read by the testbench at the end

	b_hold: assert property (@(posedge se_clk) disable iff (!se_rstn)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
	else begin
		$error("bvalid dropped before bready");
		fail_cnt++;
	end

	r_hold: assert property (@(posedge se_clk) disable iff (!se_rstn)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
	else begin
		$error("rvalid dropped before rready");
		fail_cnt++;
	end

	// descriptor frozen until the scan engine takes it
	desc_hold: assert property (@(posedge se_clk) disable iff (!se_rstn)
		desc_valid && !desc_ready |=> desc_valid && $stable(desc))
	else begin
		$error("descriptor changed or dropped while not accepted");
		fail_cnt++;
	end

	rst_quiet: assert property (@(posedge se_clk) !se_rstn |-> !(axil_rsp.awready ||
		axil_rsp.wready || axil_rsp.bvalid || axil_rsp.arready || axil_rsp.rvalid || desc_valid))
	else begin
		$error("control output high during reset");
		fail_cnt++;
	end

endmodule

// File: dv/tri_setup_tb.sv
`timescale 1ns/10ps
`include "tri_setup_settings.svh"

module tri_setup_tb;
	import tri_setup_pkg::*;

	localparam int N_CONV = 60;
	localparam int N_TRI  = 4;
	localparam int HOLD   = 24;
	// bus transactions over all five tests with some margin
	localparam int NUM_TXN = 2 * N_CONV + 32 * 9 + N_TRI * 28 + 12 + 10;

	logic      se_clk;
	logic      se_rstn;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	tri_desc_t desc;
	logic      desc_valid;
	logic      desc_ready;

	integer      seed = 32'hb5d0448e;
	logic [31:0] m_es [3];
	logic [31:0] m_ex [3];
	logic [31:0] m_spy;
	logic [31:0] m_vtx [4];
	logic [31:0] m_attr [3 * `TS_NUM_ATTR];
	logic [15:0] m_ns1;
	logic [15:0] m_ns2;
	logic [4:0]  m_ystat;
	tri_desc_t   exp_q [$];
	int          taken_cnt;
	logic        c2_done;

	tb_clk_gen u_clk (
		.se_clk  (se_clk),
		.se_rstn (se_rstn)
	);

	tri_setup_top i_tri_setup_top (
		.se_clk     (se_clk),
		.se_rstn    (se_rstn),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.desc       (desc),
		.desc_valid (desc_valid),
		.desc_ready (desc_ready)
	);

	bind tri_setup_top tri_setup_asserts u_asserts (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			abort_run($sformatf("Fail %s: got 0x%08h, expected 0x%08h", name, got, want));
	endtask

	// ieee single to 16.16 truncated toward zero
	function automatic logic [31:0] flt_to_fix(input logic [31:0] f);
		int          e;
		logic [63:0] mag;
		e = int'(f[30:23]) - 127;
		mag = {40'h0, 1'b1, f[22:0]}; // value scaled by 2^23
		if (f[30:23] == 8'h0)
			return 32'h0;
		if (e >= 15)
			return f[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
		if (e >= 7)
			mag = mag << (e - 7);
		else
			mag = mag >> (7 - e);
		return f[31] ? -mag[31:0] : mag[31:0];
	endfunction

	function automatic logic [15:0] scan_count(input logic [31:0] fx, input logic lt,
		input logic vf);
		logic up;
		up = (fx[15:0] != 16'h0) && ((vf && m_ystat[0] && lt) || (vf && !m_ystat[0]));
		return fx[31:16] + 16'(up);
	endfunction

	function automatic logic is_mapped(input logic [7:0] a);
		return (a[1:0] == 2'b00) && (a <= `TS_REG_V2Y || (a >= `TS_REG_ATTR_BASE &&
			a < `TS_REG_ATTR_BASE + 12 * `TS_NUM_ATTR));
	endfunction

	function automatic logic [31:0] rand_float();
		logic [7:0]  e;
		logic        s;
		logic [22:0] m;
		e = 8'(100 + $unsigned($random(seed)) % 51);
		s = 1'($random(seed));
		m = 23'($random(seed));
		return {s, e, m};
	endfunction

	// positive float below 2^15 with or without a fractional part
	function automatic logic [31:0] ns_float(input logic want_frac);
		logic [7:0]  e;
		logic [22:0] m;
		int          sh;
		e = 8'(127 + $unsigned($random(seed)) % 15);
		m = 23'($random(seed));
		sh = 150 - int'(e); // mantissa bits below the binary point
		m = m & ~((23'h1 << sh) - 23'h1);
		if (want_frac)
			m[sh - 1] = 1'b1;
		return {1'b0, e, m};
	endfunction

	function automatic logic [31:0] expected_word(input logic [7:0] a);
		logic [31:0] w;
		w = 32'h0;
		if (!is_mapped(a) || a == `TS_REG_COMMIT)
			w = 32'h0;
		else if (a == `TS_REG_YSTAT)
			w = {27'h0, m_ystat};
		else if (a <= `TS_REG_E3S)
			w = m_es[(a - `TS_REG_E1S) >> 2];
		else if (a <= `TS_REG_E3X)
			w = m_ex[(a - `TS_REG_E1X) >> 2];
		else if (a == `TS_REG_NS1)
			w = {16'h0, m_ns1};
		else if (a == `TS_REG_NS2)
			w = {16'h0, m_ns2};
		else if (a == `TS_REG_SPY)
			w = m_spy;
		else if (a <= `TS_REG_V2Y)
			w = m_vtx[(a - `TS_REG_V0X) >> 2];
		else
			w = m_attr[(a - `TS_REG_ATTR_BASE) >> 2];
		return w;
	endfunction

	task automatic capture_commit(input logic [1:0] ctrl);
		tri_desc_t d;
		d = '0;
		for (int i = 0; i < 3; i++) begin
			d.es[i] = m_es[i];
			d.ex[i] = m_ex[i];
		end
		d.spx = m_ex[1][31:16];
		if (m_ex[1][31] && m_ex[1][15:0] != 16'h0)
			d.spx = d.spx + 16'h1; // toward +x
		d.spy = m_spy[31:16];
		d.ns1 = m_ns1;
		d.ns2 = m_ns2;
		for (int i = 0; i < `TS_NUM_ATTR; i++) begin
			d.attr[i].start = m_attr[3 * i];
			d.attr[i].dx    = m_attr[3 * i + 1];
			d.attr[i].dy    = m_attr[3 * i + 2];
		end
		d.start_x   = m_vtx[0];
		d.start_y   = m_vtx[1];
		d.end_x     = m_vtx[2];
		d.end_y     = m_vtx[3];
		d.scan_dir  = ctrl[0];
		d.line_mode = ctrl[1];
		exp_q.push_back(d);
	endtask

	task automatic apply_write(input logic [7:0] a, input logic [31:0] d, input logic [3:0] strb,
		output logic [1:0] resp);
		logic [31:0] fx;
		fx = flt_to_fix(d);
		if (strb != 4'hF || !is_mapped(a)) begin
			resp = RESP_SLVERR;
		end else begin
			resp = RESP_OKAY;
			if (a == `TS_REG_COMMIT)
				capture_commit(d[1:0]);
			else if (a == `TS_REG_YSTAT)
				m_ystat = d[4:0];
			else if (a <= `TS_REG_E3S)
				m_es[(a - `TS_REG_E1S) >> 2] = fx;
			else if (a <= `TS_REG_E3X)
				m_ex[(a - `TS_REG_E1X) >> 2] = fx;
			else if (a == `TS_REG_NS1)
				m_ns1 = scan_count(fx, m_ystat[3], m_ystat[1]);
			else if (a == `TS_REG_NS2)
				m_ns2 = scan_count(fx, m_ystat[4], m_ystat[2]);
			else if (a == `TS_REG_SPY)
				m_spy = fx;
			else if (a <= `TS_REG_V2Y)
				m_vtx[(a - `TS_REG_V0X) >> 2] = d;
			else
				m_attr[(a - `TS_REG_ATTR_BASE) >> 2] = d;
		end
	endtask

	task automatic write_bus(input logic [7:0] a, input logic [31:0] d, input logic [3:0] strb,
		output logic [1:0] resp);
		@(posedge se_clk);
		#1;
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = a;
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = d;
		axil_req.wstrb   = strb;
		do @(negedge se_clk); while (!axil_rsp.awready);
		expect_eq("wready", 32'(axil_rsp.wready), 32'h1); // rises with awready
		@(posedge se_clk);
		#1;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		axil_req.bready  = 1'b1;
		do @(negedge se_clk); while (!axil_rsp.bvalid);
		resp = axil_rsp.bresp;
		@(posedge se_clk);
		#1 axil_req.bready = 1'b0;
	endtask

	task automatic read_bus(input logic [7:0] a, output logic [31:0] d, output logic [1:0] resp);
		@(posedge se_clk);
		#1;
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = a;
		do @(negedge se_clk); while (!axil_rsp.arready);
		@(posedge se_clk);
		#1;
		axil_req.arvalid = 1'b0;
		axil_req.rready  = 1'b1;
		do @(negedge se_clk); while (!axil_rsp.rvalid);
		d    = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge se_clk);
		#1 axil_req.rready = 1'b0;
	endtask

	task automatic stage_word(input logic [7:0] a, input logic [31:0] d, input logic [3:0] strb);
		logic [1:0] want;
		logic [1:0] resp;
		apply_write(a, d, strb, want);
		write_bus(a, d, strb, resp);
		expect_eq($sformatf("bresp @%02h", a), 32'(resp), 32'(want));
	endtask

	task automatic read_back(input logic [7:0] a);
		logic [31:0] d;
		logic [1:0]  resp;
		read_bus(a, d, resp);
		expect_eq($sformatf("rresp @%02h", a), 32'(resp),
			32'(is_mapped(a) ? RESP_OKAY : RESP_SLVERR));
		expect_eq($sformatf("rdata @%02h", a), d, expected_word(a));
	endtask

	task automatic load_triangle();
		stage_word(`TS_REG_YSTAT, $random(seed), 4'hF);
		for (int i = 0; i < 3; i++) begin
			stage_word(8'(`TS_REG_E1S + 4 * i), rand_float(), 4'hF);
			stage_word(8'(`TS_REG_E1X + 4 * i), rand_float(), 4'hF);
		end
		stage_word(`TS_REG_NS1, ns_float(1'($random(seed))), 4'hF);
		stage_word(`TS_REG_NS2, ns_float(1'($random(seed))), 4'hF);
		stage_word(`TS_REG_SPY, rand_float(), 4'hF);
		for (int i = 0; i < 4; i++)
			stage_word(8'(`TS_REG_V0X + 4 * i), $random(seed), 4'hF);
		for (int i = 0; i < 3 * `TS_NUM_ATTR; i++)
			stage_word(8'(`TS_REG_ATTR_BASE + 4 * i), $random(seed), 4'hF);
	endtask

	task automatic compare_desc(input tri_desc_t got, input tri_desc_t want);
		for (int i = 0; i < 3; i++) begin
			expect_eq($sformatf("desc.es[%0d]", i), got.es[i], want.es[i]);
			expect_eq($sformatf("desc.ex[%0d]", i), got.ex[i], want.ex[i]);
		end
		expect_eq("desc.spx", 32'(got.spx), 32'(want.spx));
		expect_eq("desc.spy", 32'(got.spy), 32'(want.spy));
		expect_eq("desc.ns1", 32'(got.ns1), 32'(want.ns1));
		expect_eq("desc.ns2", 32'(got.ns2), 32'(want.ns2));
		for (int i = 0; i < `TS_NUM_ATTR; i++) begin
			expect_eq($sformatf("desc.attr[%0d].start", i), got.attr[i].start, want.attr[i].start);
			expect_eq($sformatf("desc.attr[%0d].dx", i), got.attr[i].dx, want.attr[i].dx);
			expect_eq($sformatf("desc.attr[%0d].dy", i), got.attr[i].dy, want.attr[i].dy);
		end
		expect_eq("desc.start_x", got.start_x, want.start_x);
		expect_eq("desc.start_y", got.start_y, want.start_y);
		expect_eq("desc.end_x", got.end_x, want.end_x);
		expect_eq("desc.end_y", got.end_y, want.end_y);
		expect_eq("desc.scan_dir", 32'(got.scan_dir), 32'(want.scan_dir));
		expect_eq("desc.line_mode", 32'(got.line_mode), 32'(want.line_mode));
	endtask

	// handshake completes on the next rising edge
	always @(negedge se_clk) begin
		if (se_rstn && desc_valid && desc_ready) begin
			if (exp_q.size() == 0) begin
				abort_run("descriptor handed out without a matching commit");
			end else begin
				compare_desc(desc, exp_q.pop_front());
				taken_cnt++;
			end
		end
	end

	initial begin
		repeat (NUM_TXN * 200) @(posedge se_clk);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		logic [7:0]  a;
		logic [31:0] w;
		logic [31:0] d;
		logic [1:0]  resp;
		int          idx;
		int          n0;
		axil_req   = '0;
		desc_ready = 1'b1;
		taken_cnt  = 0;
		c2_done    = 1'b0;
		m_spy      = '0;
		m_ns1      = '0;
		m_ns2      = '0;
		m_ystat    = '0;
		foreach (m_es[i]) m_es[i] = '0;
		foreach (m_ex[i]) m_ex[i] = '0;
		foreach (m_vtx[i]) m_vtx[i] = '0;
		foreach (m_attr[i]) m_attr[i] = '0;
		@(posedge se_rstn);

		// float conversion on slopes, intercepts and sample y
		for (int i = 0; i < N_CONV; i++) begin
			idx = $unsigned($random(seed)) % 7;
			a = (idx < 6) ? 8'(`TS_REG_E1S + 4 * idx) : `TS_REG_SPY;
			stage_word(a, rand_float(), 4'hF);
			read_back(a);
		end

		// scan count rounding over every ystat value
		for (int ys = 0; ys < 32; ys++) begin
			stage_word(`TS_REG_YSTAT, 32'(ys), 4'hF);
			for (int f = 0; f < 2; f++) begin
				stage_word(`TS_REG_NS1, ns_float(f[0]), 4'hF);
				stage_word(`TS_REG_NS2, ns_float(f[0]), 4'hF);
				read_back(`TS_REG_NS1);
				read_back(`TS_REG_NS2);
			end
		end

		for (int t = 0; t < N_TRI; t++) begin
			load_triangle();
			stage_word(`TS_REG_COMMIT, $random(seed), 4'hF);
			while (exp_q.size() != 0) @(negedge se_clk);
		end
		expect_eq("taken_cnt", taken_cnt, N_TRI);

		// scan engine stalls on the first descriptor
		@(posedge se_clk);
		#1 desc_ready = 1'b0;
		stage_word(`TS_REG_COMMIT, $random(seed), 4'hF);
		n0 = taken_cnt;
		stage_word(`TS_REG_E1S, rand_float(), 4'hF);
		stage_word(`TS_REG_E2X, rand_float(), 4'hF);
		stage_word(`TS_REG_V2Y, $random(seed), 4'hF);
		stage_word(8'(`TS_REG_ATTR_BASE + 8), $random(seed), 4'hF);
		read_bus(`TS_REG_COMMIT, d, resp);
		expect_eq("rresp pending", 32'(resp), 32'(RESP_OKAY));
		expect_eq("rdata pending", d, 32'h1);
		fork
			begin
				stage_word(`TS_REG_COMMIT, $random(seed), 4'hF);
				expect_eq("taken_cnt before commit B", 32'(taken_cnt > n0), 32'h1);
				c2_done = 1'b1;
			end
			begin
				repeat (HOLD) @(posedge se_clk);
				expect_eq("bvalid of held commit", 32'(c2_done), 32'h0);
				#1 desc_ready = 1'b1;
			end
		join
		while (exp_q.size() != 0) @(negedge se_clk);

		// error responses leave the registers alone
		w = $random(seed);
		stage_word(`TS_REG_E3S, w, 4'h7);
		read_back(`TS_REG_E3S);
		stage_word(8'h3C, w, 4'hF); // hole before the attributes
		read_back(8'h3C);
		stage_word(8'h70, w, 4'hF);
		read_back(8'h70);
		stage_word(8'h0A, w, 4'hF);
		read_back(8'h0A);
		stage_word(`TS_REG_COMMIT, 32'h3, 4'h1);
		read_bus(`TS_REG_COMMIT, d, resp);
		expect_eq("rresp pending", 32'(resp), 32'(RESP_OKAY));
		expect_eq("rdata pending", d, 32'h0);
		expect_eq("taken_cnt", taken_cnt, N_TRI + 2);

		repeat (4) @(posedge se_clk);
		if (i_tri_setup_top.u_asserts.fail_cnt == 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			abort_run("bound assertions reported errors");
		end
	end

endmodule

// File: logic/flt_fx.sv
`timescale 1ns/10ps

module flt_fx (
	input  tri_setup_pkg::flt_word_u flt,
	output tri_setup_pkg::flt_word_u fxp
);

	logic [23:0] mant;
	logic [31:0] mag;
	logic        sat;
	logic        zero;

	assign mant = {1'b1, flt.flt.man};
	assign zero = (flt.flt.expo == 8'd0);   // zero and denormals
	assign sat  = (flt.flt.expo >= 8'd142); // |x| >= 2^15, inf, nan

	// 1.m * 2^(e-127) * 2^16 is mant shifted by e-134
	always_comb begin
		if (flt.flt.expo >= 8'd134)
			mag = {8'h0, mant} << (flt.flt.expo - 8'd134);
		else
			mag = {8'h0, mant} >> (8'd134 - flt.flt.expo);
	end

	always_comb begin
		if (zero) begin
			fxp = '0;
		end else if (sat) begin
			if (flt.flt.sign)
				fxp = 32'h8000_0000;
			else
				fxp = 32'h7FFF_FFFF;
		end else if (flt.flt.sign) begin
			fxp = -mag; // truncated magnitude, so toward zero
		end else begin
			fxp = mag;
		end
	end

endmodule

// File: logic/tri_setup_top.sv
`timescale 1ns/10ps

module tri_setup_top (
	input  logic                      se_clk,
	input  logic                      se_rstn,
	input  tri_setup_pkg::axil_req_t  axil_req,
	output tri_setup_pkg::axil_rsp_t  axil_rsp,
	output tri_setup_pkg::tri_desc_t  desc,
	output logic                      desc_valid,
	input  logic                      desc_ready
);
	import tri_setup_pkg::*;

	stage_ld_t   ld;
	logic [31:0] wdata;
	logic [31:0] fxp_out;
	tri_desc_t   stage_view;
	logic [4:0]  ystat_view;

	setup_decode u_decode (
		.se_clk     (se_clk),
		.se_rstn    (se_rstn),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.desc_valid (desc_valid),
		.stage_view (stage_view),
		.ystat_view (ystat_view),
		.ld         (ld),
		.wdata      (wdata)
	);

	// write data to 16.16 for slopes, intercepts, ns and spy
	flt_fx u_flt_fx (
		.flt (wdata),
		.fxp (fxp_out)
	);

	setup_execute u_execute (
		.se_clk     (se_clk),
		.se_rstn    (se_rstn),
		.ld         (ld),
		.wdata      (wdata),
		.fxp_in     (fxp_out),
		.stage_view (stage_view),
		.ystat_view (ystat_view)
	);

	des_reg u_des_reg (
		.se_clk      (se_clk),
		.se_rstn     (se_rstn),
		.commit      (ld.commit),
		.commit_ctrl (wdata[1:0]),  // scan_dir, line_mode
		.staged      (stage_view),
		.desc        (desc),
		.desc_valid  (desc_valid),
		.desc_ready  (desc_ready)
	);

endmodule

// File: setup_regs/des_reg.sv
`timescale 1ns/10ps

module des_reg (
	input  logic                      se_clk,
	input  logic                      se_rstn,
	input  logic                      commit,
	input  logic [1:0]                commit_ctrl,
	input  tri_setup_pkg::tri_desc_t  staged,
	output tri_setup_pkg::tri_desc_t  desc,
	output logic                      desc_valid,
	input  logic                      desc_ready
);
	import tri_setup_pkg::*;

	flt_word_u e2x_w;
	logic      spx_inc;
	tri_desc_t desc_d;

	assign e2x_w = staged.ex[1];

	// negative intercept with a fraction rounds toward +x
	assign spx_inc = e2x_w.fix.ip[15] & (|e2x_w.fix.frac);

	always_comb begin
		desc_d           = staged;
		desc_d.spx       = e2x_w.fix.ip + {15'h0, spx_inc};
		desc_d.scan_dir  = commit_ctrl[0];
		desc_d.line_mode = commit_ctrl[1];
	end

	always_ff @(posedge se_clk or negedge se_rstn) begin
		if (!se_rstn)
			desc <= '0;
		else if (commit)
			desc <= desc_d; // whole set in one edge
	end

	// commit is held off upstream while valid is high
	always_ff @(posedge se_clk or negedge se_rstn) begin
		if (!se_rstn) begin
			desc_valid <= 1'b0;
		end else if (commit) begin
			desc_valid <= 1'b1;
		end else if (desc_ready) begin
			desc_valid <= 1'b0;
		end
	end

endmodule

// File: setup_regs/setup_decode.sv
`timescale 1ns/10ps
`include "tri_setup_settings.svh"

module setup_decode (
	input  logic                      se_clk,
	input  logic                      se_rstn,
	input  tri_setup_pkg::axil_req_t  axil_req,
	output tri_setup_pkg::axil_rsp_t  axil_rsp,
	input  logic                      desc_valid,
	input  tri_setup_pkg::tri_desc_t  stage_view,
	input  logic [4:0]                ystat_view,
	output tri_setup_pkg::stage_ld_t  ld,
	output logic [31:0]               wdata
);
	import tri_setup_pkg::*;

	logic        aw_rdy;
	logic        ar_rdy;
	logic        bvalid;
	logic        rvalid;
	logic [1:0]  bresp;
	logic [1:0]  rresp;
	logic [31:0] rdata;
	logic [31:0] rd_word;
	stage_ld_t   wmap;
	stage_ld_t   rmap;
	logic        commit_hold;
	logic        wr_go;
	logic        wr_fire;
	logic        wr_ok;
	logic        ar_go;
	logic        rd_fire;

	function automatic stage_ld_t hit(input ld_cls_e c, input logic [`TS_ADDR_W-1:0] off);
		stage_ld_t m;
		m = '0;
		m.ld = 1'b1;
		m.cls = c;
		m.idx = off[5:2];
		return m;
	endfunction

	function automatic stage_ld_t addr_map(input logic [`TS_ADDR_W-1:0] a);
		stage_ld_t m;
		m = '0;
		if (a[1:0] == 2'b00) begin
			if (a == `TS_REG_COMMIT)
				m.commit = 1'b1;
			else if (a == `TS_REG_YSTAT)
				m = hit(CL_YSTAT, '0);
			else if (a >= `TS_REG_E1S && a <= `TS_REG_E3S)
				m = hit(CL_ESLOPE, a - `TS_REG_E1S);
			else if (a >= `TS_REG_E1X && a <= `TS_REG_E3X)
				m = hit(CL_EINT, a - `TS_REG_E1X);
			else if (a == `TS_REG_NS1)
				m = hit(CL_NS1, '0);
			else if (a == `TS_REG_NS2)
				m = hit(CL_NS2, '0);
			else if (a == `TS_REG_SPY)
				m = hit(CL_SPY, '0);
			else if (a >= `TS_REG_V0X && a <= `TS_REG_V2Y)
				m = hit(CL_VTX, a - `TS_REG_V0X);
			else if (a >= `TS_REG_ATTR_BASE && a < `TS_REG_ATTR_BASE + 12 * `TS_NUM_ATTR)
				m = hit(CL_ATTR, a - `TS_REG_ATTR_BASE);
		end
		return m;
	endfunction

	assign wmap = addr_map(axil_req.awaddr);
	assign rmap = addr_map(axil_req.araddr);

	// no second commit while the scan engine still owns a descriptor
	assign commit_hold = wmap.commit & desc_valid;
	assign wr_go   = axil_req.awvalid & axil_req.wvalid & ~bvalid & ~aw_rdy & ~commit_hold;
	assign wr_fire = aw_rdy & axil_req.awvalid & axil_req.wvalid;
	assign wr_ok   = (wmap.ld | wmap.commit) & (axil_req.wstrb == 4'hF);
	assign ar_go   = axil_req.arvalid & ~rvalid & ~ar_rdy;
	assign rd_fire = ar_rdy & axil_req.arvalid;

	assign ld    = (wr_fire && wr_ok) ? wmap : '0;
	assign wdata = axil_req.wdata;

	always_comb begin
		rd_word = '0;
		if (rmap.commit) begin
			rd_word = {31'h0, desc_valid}; // pending
		end else if (rmap.ld) begin
			case (rmap.cls)
				CL_ESLOPE: rd_word = stage_view.es[rmap.idx[1:0]];
				CL_EINT:   rd_word = stage_view.ex[rmap.idx[1:0]];
				CL_NS1:    rd_word = {16'h0, stage_view.ns1};
				CL_NS2:    rd_word = {16'h0, stage_view.ns2};
				CL_SPY:    rd_word = {stage_view.spy, stage_view.spx};
				CL_YSTAT:  rd_word = {27'h0, ystat_view};
				CL_VTX: begin
					case (rmap.idx[1:0])
						2'd0:    rd_word = stage_view.start_x;
						2'd1:    rd_word = stage_view.start_y;
						2'd2:    rd_word = stage_view.end_x;
						default: rd_word = stage_view.end_y;
					endcase
				end
				default: begin
					for (int i = 0; i < `TS_NUM_ATTR; i++) begin
						if (rmap.idx == 4'(3 * i))
							rd_word = stage_view.attr[i].start;
						if (rmap.idx == 4'(3 * i + 1))
							rd_word = stage_view.attr[i].dx;
						if (rmap.idx == 4'(3 * i + 2))
							rd_word = stage_view.attr[i].dy;
					end
				end
			endcase
		end
	end

	always_ff @(posedge se_clk or negedge se_rstn) begin
		if (!se_rstn) begin
			aw_rdy <= 1'b0;
			bvalid <= 1'b0;
			bresp  <= RESP_OKAY;
		end else begin
			aw_rdy <= wr_go; // one cycle pulse
			if (wr_fire) begin
				bvalid <= 1'b1;
				bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			end else if (axil_req.bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge se_clk or negedge se_rstn) begin
		if (!se_rstn) begin
			ar_rdy <= 1'b0;
			rvalid <= 1'b0;
			rresp  <= RESP_OKAY;
			rdata  <= '0;
		end else begin
			ar_rdy <= ar_go;
			if (rd_fire) begin
				rvalid <= 1'b1;
				rdata  <= rd_word;
				rresp  <= (rmap.ld | rmap.commit) ? RESP_OKAY : RESP_SLVERR;
			end else if (axil_req.rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	assign axil_rsp.awready = aw_rdy;
	assign axil_rsp.wready  = aw_rdy;
	assign axil_rsp.bvalid  = bvalid;
	assign axil_rsp.bresp   = bresp;
	assign axil_rsp.arready = ar_rdy;
	assign axil_rsp.rvalid  = rvalid;
	assign axil_rsp.rdata   = rdata;
	assign axil_rsp.rresp   = rresp;

endmodule

// File: setup_regs/setup_execute.sv
`timescale 1ns/10ps
`include "tri_setup_settings.svh"

module setup_execute (
	input  logic                      se_clk,
	input  logic                      se_rstn,
	input  tri_setup_pkg::stage_ld_t  ld,
	input  logic [31:0]               wdata,
	input  logic [31:0]               fxp_in,
	output tri_setup_pkg::tri_desc_t  stage_view,
	output logic [4:0]                ystat_view
);
	import tri_setup_pkg::*;

	logic [2:0][31:0] es_q;
	logic [2:0][31:0] ex_q;
	logic [15:0]      ns1_q;
	logic [15:0]      ns2_q;
	flt_word_u        spy_q;
	logic [31:0]      v0x_q;
	logic [31:0]      v0y_q;
	logic [31:0]      v2x_q;
	logic [31:0]      v2y_q;
	attr_plane_t [`TS_NUM_ATTR-1:0] attr_q;
	logic [4:0]       ystat_q;   // {y2_lt_y0, y1_lt_y0, y2f, y1f, y0f}
	flt_word_u        fx;
	logic             frac_nz;
	logic             ns1_up;
	logic             ns2_up;

	assign fx = fxp_in;
	assign frac_nz = |fx.fix.frac;

	// round up only when the edge starts on a fractional y
	assign ns1_up = frac_nz & ystat_q[1] & (~ystat_q[0] | ystat_q[3]);
	assign ns2_up = frac_nz & ystat_q[2] & (~ystat_q[0] | ystat_q[4]);

	always_ff @(posedge se_clk or negedge se_rstn) begin
		if (!se_rstn) begin
			es_q    <= '0;
			ex_q    <= '0;
			ns1_q   <= '0;
			ns2_q   <= '0;
			spy_q   <= '0;
			v0x_q   <= '0;
			v0y_q   <= '0;
			v2x_q   <= '0;
			v2y_q   <= '0;
			attr_q  <= '0;
			ystat_q <= '0;
		end else if (ld.ld) begin
			case (ld.cls)
				CL_ESLOPE: es_q[ld.idx[1:0]] <= fxp_in;
				CL_EINT:   ex_q[ld.idx[1:0]] <= fxp_in;
				CL_NS1:    ns1_q <= fx.fix.ip + {15'h0, ns1_up};
				CL_NS2:    ns2_q <= fx.fix.ip + {15'h0, ns2_up};
				CL_SPY:    spy_q <= fxp_in;
				CL_YSTAT:  ystat_q <= wdata[4:0];
				CL_VTX: begin
					case (ld.idx[1:0])
						2'd0:    v0x_q <= wdata;
						2'd1:    v0y_q <= wdata;
						2'd2:    v2x_q <= wdata;
						default: v2y_q <= wdata;
					endcase
				end
				default: begin
					for (int i = 0; i < `TS_NUM_ATTR; i++) begin
						if (ld.idx == 4'(3 * i))
							attr_q[i].start <= wdata;
						if (ld.idx == 4'(3 * i + 1))
							attr_q[i].dx <= wdata;
						if (ld.idx == 4'(3 * i + 2))
							attr_q[i].dy <= wdata;
					end
				end
			endcase
		end
	end

	always_comb begin
		stage_view         = '0;
		stage_view.es      = es_q;
		stage_view.ex      = ex_q;
		stage_view.ns1     = ns1_q;
		stage_view.ns2     = ns2_q;
		stage_view.spy     = spy_q.fix.ip;
		stage_view.spx     = spy_q.fix.frac; // spy fraction until des_reg forms spx
		stage_view.attr    = attr_q;
		stage_view.start_x = v0x_q;
		stage_view.start_y = v0y_q;
		stage_view.end_x   = v2x_q;
		stage_view.end_y   = v2y_q;
	end

	assign ystat_view = ystat_q;

endmodule

// File: tri_setup_top.f
+incdir+common
common/tri_setup_pkg.sv
logic/flt_fx.sv
setup_regs/setup_decode.sv
setup_regs/setup_execute.sv
setup_regs/des_reg.sv
logic/tri_setup_top.sv
dv/tb_clk_gen.sv
dv/tri_setup_asserts.sv
dv/tri_setup_tb.sv
